// ==== design/zx_defs.svh ====
`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

////////////////////////////////////////////////////////////
// memory geometry
////////////////////////////////////////////////////////////

// word address into the 16-bit DRAM
`define DRAM_AW         16
// 8 pages of 16 KB
`define PAGE_W          3
// word offset inside one 16 KB window
`define WIN_OFS_W       13
`define NUM_WIN         4

////////////////////////////////////////////////////////////
// i/o ports and screens
////////////////////////////////////////////////////////////

// page port, a[15:14] picks the window
`define PORT_PAGE_LO    8'hF7
// screen port, data bit 3 picks the screen
`define PORT_SCR_LO     8'hFD
`define SCR0_PAGE       5
`define SCR1_PAGE       7

// video line timing and dram pipeline
`define LINE_CYCLES     64
`define FETCH_WORDS     8
`define LINES_PER_FRAME 4
`define RD_LAT          2

`endif

// ==== design/zx_pkg.sv ====
`include "zx_defs.svh"

package zx_pkg;

	typedef logic [7:0]              byte_t;
	typedef logic [15:0]             word_t;
	typedef logic [`PAGE_W-1:0]      page_t;
	typedef logic [`DRAM_AW-1:0]     word_addr_t;
	typedef logic [15:0]             zaddr_t;
	// bit 1 is the high byte lane
	typedef logic [1:0]              bsel_t;

	typedef enum logic {SRC_CPU, SRC_VIDEO} src_t;

	typedef enum logic [1:0] {
		CPU_IDLE,
		CPU_REQ,
		CPU_WAIT,
		CPU_DONE
	} cpu_state_t;

	// one page per cpu window
	typedef page_t [`NUM_WIN-1:0] page_map_t;

	typedef struct packed {
		logic       valid;
		logic       rnw;
		src_t       src;
		word_addr_t addr;
		bsel_t      bsel;
		word_t      wdata;
	} dram_req_t;

	typedef struct packed {
		logic  valid;
		src_t  src;
		word_t rdata;
	} dram_rsp_t;

endpackage

// ==== design/port_regs.sv ====
`include "zx_defs.svh"

module port_regs
	import zx_pkg::*;
(
	input  logic      fclk,
	input  logic      reset,
	input  zaddr_t    z_a,
	input  byte_t     z_din,
	input  logic      iorq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	output page_map_t page_map,
	output logic      screen,
	output byte_t     io_dout,
	output logic      io_dout_en
);

	logic io_wr;
	logic io_wr_q;
	logic io_rd;
	logic page_hit;
	logic scr_hit;
	logic page_wr;
	logic scr_wr;

	assign io_wr    = ~iorq_n & ~wr_n;
	assign io_rd    = ~iorq_n & ~rd_n;
	assign page_hit = (z_a[7:0] == `PORT_PAGE_LO);
	assign scr_hit  = (z_a[7:0] == `PORT_SCR_LO);

	// one write per strobe on its leading edge
	assign page_wr = io_wr & ~io_wr_q & page_hit;
	assign scr_wr  = io_wr & ~io_wr_q & scr_hit;

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			io_wr_q    <= 1'b0;
			screen     <= 1'b0;
			io_dout_en <= 1'b0;
			for (int i = 0; i < `NUM_WIN; i++)
				page_map[i] <= page_t'(i);
		end
		else
		begin
			io_wr_q    <= io_wr;
			io_dout_en <= io_rd & page_hit;
			if (page_wr)
				page_map[z_a[15:14]] <= z_din[`PAGE_W-1:0];
			if (scr_wr)
				screen <= z_din[3];
		end
	end

	// zero-extended page read-back
	always_ff @(posedge fclk)
	begin
		io_dout <= byte_t'(page_map[z_a[15:14]]);
	end

	a_port_excl: assert property (@(posedge fclk) disable iff (reset)
		page_wr |=> $stable(screen))
		else $error("page port write changed the screen bit");

endmodule

// ==== design/cpu_mem.sv ====
`include "zx_defs.svh"

module cpu_mem
	import zx_pkg::*;
(
	input  logic      fclk,
	input  logic      reset,
	input  zaddr_t    z_a,
	input  byte_t     z_din,
	input  logic      mreq_n,
	input  logic      rd_n,
	input  logic      wr_n,
	input  page_map_t page_map,
	output dram_req_t cpu_req,
	input  logic      cpu_gnt,
	input  dram_rsp_t cpu_rsp,
	output logic      wait_n,
	output byte_t     mem_dout,
	output logic      mem_dout_en
);

	cpu_state_t state;
	logic       mem_rd;
	logic       mem_wr;
	page_t      win_page;
	logic       req_rnw;
	word_addr_t req_addr;
	bsel_t      req_bsel;
	byte_t      req_wbyte;

	assign mem_rd   = ~mreq_n & ~rd_n;
	assign mem_wr   = ~mreq_n & ~wr_n;
	assign win_page = page_map[z_a[15:14]];

	always_comb
	begin
		cpu_req.valid = (state == CPU_REQ);
		cpu_req.rnw   = req_rnw;
		cpu_req.src   = SRC_CPU;
		cpu_req.addr  = req_addr;
		cpu_req.bsel  = req_bsel;
		// same byte on both lanes, bsel picks
		cpu_req.wdata = {req_wbyte, req_wbyte};
	end

	////////////////////////////////////////////////////////////
	// access FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			state       <= CPU_IDLE;
			wait_n      <= 1'b1;
			mem_dout_en <= 1'b0;
		end
		else
		begin
			case (state)
				CPU_IDLE:
					if (mem_rd | mem_wr)
					begin
						state  <= CPU_REQ;
						wait_n <= 1'b0;
					end
				CPU_REQ:
					if (cpu_gnt)
					begin
						state  <= req_rnw ? CPU_WAIT : CPU_DONE;
						wait_n <= ~req_rnw;
					end
				CPU_WAIT:
					if (cpu_rsp.valid)
					begin
						state       <= CPU_DONE;
						wait_n      <= 1'b1;
						mem_dout_en <= 1'b1;
					end
				// hold until strobes go high
				CPU_DONE:
					if (!(mem_rd | mem_wr))
					begin
						state       <= CPU_IDLE;
						mem_dout_en <= 1'b0;
					end
				default:
					state <= CPU_IDLE;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		if (state == CPU_IDLE)
		begin
			req_rnw   <= mem_rd;
			req_addr  <= {win_page, z_a[`WIN_OFS_W:1]};
			req_bsel  <= z_a[0] ? 2'b10 : 2'b01;
			req_wbyte <= z_din;
		end
		if (state == CPU_WAIT && cpu_rsp.valid)
			mem_dout <= req_bsel[1] ? cpu_rsp.rdata[15:8] : cpu_rsp.rdata[7:0];
	end

	a_req_stable: assert property (@(posedge fclk) disable iff (reset)
		cpu_req.valid && !cpu_gnt |=> $stable(cpu_req))
		else $error("cpu request changed before grant");

endmodule

// ==== design/dram_arbiter.sv ====
module dram_arbiter
	import zx_pkg::*;
(
	input  logic      fclk,
	input  logic      reset,
	input  dram_req_t cpu_req,
	input  dram_req_t vid_req,
	output logic      cpu_gnt,
	output logic      vid_gnt,
	output dram_req_t dram_req,
	input  dram_rsp_t dram_rsp,
	output dram_rsp_t cpu_rsp,
	output dram_rsp_t vid_rsp
);

	logic [2:0] rd_cnt;
	logic       rd_acc;

	////////////////////////////////////////////////////////////
	// fixed priority grant with video first
	////////////////////////////////////////////////////////////

	assign vid_gnt = vid_req.valid;
	assign cpu_gnt = cpu_req.valid & ~vid_req.valid;

	// idle cpu request carries valid low when nobody asks
	assign dram_req = vid_req.valid ? vid_req : cpu_req;

	assign rd_acc = dram_req.valid & dram_req.rnw;

	////////////////////////////////////////////////////////////
	// response steering by src
	////////////////////////////////////////////////////////////

	always_comb
	begin
		cpu_rsp       = dram_rsp;
		vid_rsp       = dram_rsp;
		cpu_rsp.valid = dram_rsp.valid && (dram_rsp.src == SRC_CPU);
		vid_rsp.valid = dram_rsp.valid && (dram_rsp.src == SRC_VIDEO);
	end

	// reads in flight inside the dram pipeline
	always_ff @(posedge fclk)
	begin
		if (reset)
			rd_cnt <= '0;
		else
		begin
			case ({rd_acc, dram_rsp.valid})
				2'b10:
					rd_cnt <= rd_cnt + 3'd1;
				2'b01:
					rd_cnt <= rd_cnt - 3'd1;
				default:
					rd_cnt <= rd_cnt;
			endcase
		end
	end

	a_rsp_owed: assert property (@(posedge fclk) disable iff (reset)
		dram_rsp.valid |-> (rd_cnt != 3'd0))
		else $error("dram response with no read outstanding");

endmodule

// ==== design/dram_ctrl.sv ====
`include "zx_defs.svh"

module dram_ctrl
	import zx_pkg::*;
(
	input  logic      fclk,
	input  dram_req_t dram_req,
	output dram_rsp_t dram_rsp
);

	word_t     mem [0:(1 << `DRAM_AW) - 1];
	dram_rsp_t pipe [`RD_LAT];

	////////////////////////////////////////////////////////////
	// write port with byte lanes
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (dram_req.valid && !dram_req.rnw)
		begin
			if (dram_req.bsel[0])
				mem[dram_req.addr][7:0] <= dram_req.wdata[7:0];
			if (dram_req.bsel[1])
				mem[dram_req.addr][15:8] <= dram_req.wdata[15:8];
		end
	end

	////////////////////////////////////////////////////////////
	// read pipeline
	////////////////////////////////////////////////////////////

	// stage 0 samples the array, the rest only delay
	always_ff @(posedge fclk)
	begin
		pipe[0].valid <= dram_req.valid & dram_req.rnw;
		pipe[0].src   <= dram_req.src;
		pipe[0].rdata <= mem[dram_req.addr];
		for (int i = 1; i < `RD_LAT; i++)
			pipe[i] <= pipe[i-1];
	end

	assign dram_rsp = pipe[`RD_LAT-1];

endmodule

// ==== design/video_fetch.sv ====
`include "zx_defs.svh"

module video_fetch
	import zx_pkg::*;
(
	input  logic      fclk,
	input  logic      reset,
	input  logic      screen,
	output dram_req_t vid_req,
	input  logic      vid_gnt,
	input  dram_rsp_t vid_rsp,
	output word_t     pix_word,
	output logic      pix_strobe
);

	localparam int TM_BITS = $clog2(`LINE_CYCLES);
	localparam int FW_BITS = $clog2(`FETCH_WORDS);
	localparam int LN_BITS = $clog2(`LINES_PER_FRAME);
	localparam logic [TM_BITS-1:0] LAST_TICK = TM_BITS'(`LINE_CYCLES - 1);
	localparam logic [FW_BITS-1:0] LAST_WORD = FW_BITS'(`FETCH_WORDS - 1);
	localparam logic [LN_BITS-1:0] LAST_LINE = LN_BITS'(`LINES_PER_FRAME - 1);

	logic [TM_BITS-1:0] timer;
	logic [LN_BITS-1:0] line_cnt;
	logic [FW_BITS-1:0] word_idx;
	logic [FW_BITS:0]   pend;
	logic               busy;
	logic               line_start;
	logic               acc;
	page_t              burst_page;

	assign line_start = (timer == LAST_TICK);
	assign acc        = vid_req.valid & vid_gnt;

	// word offset is line * FETCH_WORDS + index
	always_comb
	begin
		vid_req.valid = busy;
		vid_req.rnw   = 1'b1;
		vid_req.src   = SRC_VIDEO;
		vid_req.addr  = {burst_page, {(`WIN_OFS_W - LN_BITS - FW_BITS){1'b0}}, line_cnt, word_idx};
		vid_req.bsel  = 2'b11;
		vid_req.wdata = '0;
	end

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			timer <= '0;
			line_cnt <= '0;
			word_idx <= '0;
			busy <= 1'b0;
			pend <= '0;
			pix_strobe <= 1'b0;
		end
		else
		begin
			timer <= line_start ? '0 : timer + 1'b1;
			pix_strobe <= vid_rsp.valid;
			if (line_start)
			begin
				busy     <= 1'b1;
				word_idx <= '0;
			end
			else if (acc)
			begin
				word_idx <= word_idx + 1'b1;
				if (word_idx == LAST_WORD)
				begin
					busy     <= 1'b0;
					line_cnt <= (line_cnt == LAST_LINE) ? '0 : line_cnt + 1'b1;
				end
			end
			if (acc && !vid_rsp.valid)
				pend <= pend + 1'b1;
			else if (!acc && vid_rsp.valid)
				pend <= pend - 1'b1;
		end
	end

	// screen page is taken once per burst
	always_ff @(posedge fclk)
	begin
		if (line_start)
			burst_page <= screen ? page_t'(`SCR1_PAGE) : page_t'(`SCR0_PAGE);
		pix_word <= vid_rsp.rdata;
	end

	a_burst_drained: assert property (@(posedge fclk) disable iff (reset)
		line_start |-> (pend == '0) && !busy)
		else $error("new video burst while words still outstanding");

endmodule

// ==== design/zx_core.sv ====
module zx_core
	import zx_pkg::*;
(
	input  logic   fclk,
	input  logic   reset,
	input  zaddr_t z_a,
	input  byte_t  z_din,
	output byte_t  z_dout,
	output logic   z_dout_en,
	input  logic   mreq_n,
	input  logic   iorq_n,
	input  logic   rd_n,
	input  logic   wr_n,
	output logic   wait_n,
	output word_t  pix_word,
	output logic   pix_strobe
);

	page_map_t page_map;
	logic      screen;
	byte_t     io_dout;
	logic      io_dout_en;
	byte_t     mem_dout;
	logic      mem_dout_en;

	dram_req_t cpu_req;
	dram_req_t vid_req;
	dram_req_t dram_req;
	dram_rsp_t dram_rsp;
	dram_rsp_t cpu_rsp;
	dram_rsp_t vid_rsp;
	logic      cpu_gnt;
	logic      vid_gnt;

	// memory data wins, ports and memory never answer the same cycle
	assign z_dout    = mem_dout_en ? mem_dout : io_dout;
	assign z_dout_en = mem_dout_en | io_dout_en;

	port_regs u_port_regs (
		.fclk(fclk), .reset(reset), .z_a(z_a), .z_din(z_din),
		.iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.page_map(page_map), .screen(screen),
		.io_dout(io_dout), .io_dout_en(io_dout_en)
	);

	cpu_mem u_cpu_mem (
		.fclk(fclk), .reset(reset), .z_a(z_a), .z_din(z_din),
		.mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .page_map(page_map),
		.cpu_req(cpu_req), .cpu_gnt(cpu_gnt), .cpu_rsp(cpu_rsp),
		.wait_n(wait_n), .mem_dout(mem_dout), .mem_dout_en(mem_dout_en)
	);

	video_fetch u_video_fetch (
		.fclk(fclk), .reset(reset), .screen(screen),
		.vid_req(vid_req), .vid_gnt(vid_gnt), .vid_rsp(vid_rsp),
		.pix_word(pix_word), .pix_strobe(pix_strobe)
	);

	dram_arbiter u_dram_arbiter (
		.fclk(fclk), .reset(reset),
		.cpu_req(cpu_req), .vid_req(vid_req), .cpu_gnt(cpu_gnt), .vid_gnt(vid_gnt),
		.dram_req(dram_req), .dram_rsp(dram_rsp), .cpu_rsp(cpu_rsp), .vid_rsp(vid_rsp)
	);

	dram_ctrl u_dram_ctrl (
		.fclk(fclk), .dram_req(dram_req), .dram_rsp(dram_rsp)
	);

endmodule

// ==== sim/tb_zx_core.sv ====
`include "zx_defs.svh"

module tb_zx_core
	import zx_pkg::*;
();

	typedef enum logic [2:0] {K_IOW, K_IOR, K_IONA, K_MW, K_MR, K_VID, K_CONT} kind_t;

	typedef struct packed {
		kind_t  kind;
		zaddr_t addr;
		byte_t  data;
		byte_t  exp;
	} vec_t;

	logic        fclk;
	logic        reset;
	zaddr_t      z_a;
	byte_t       z_din;
	byte_t       z_dout;
	logic        z_dout_en;
	logic        mreq_n;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        wait_n;
	word_t       pix_word;
	logic        pix_strobe;

	// stimulus table with one row per test
	string       names[$];
	vec_t        vecs[$];

	// reference model of the memory side
	page_t       model_map [`NUM_WIN];
	logic        model_scr;
	byte_t       model_mem [0:(1 << (`DRAM_AW + 1)) - 1];

	word_t       pix_hist[$];
	int          nwords;
	int          cycles;
	int          limit;
	int          errors;
	int          n_pass;
	int          n_fail;
	int unsigned seed;
	logic        filled;

	zx_core u_zx_core (
		.fclk(fclk), .reset(reset), .z_a(z_a), .z_din(z_din),
		.z_dout(z_dout), .z_dout_en(z_dout_en),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.wait_n(wait_n), .pix_word(pix_word), .pix_strobe(pix_strobe)
	);

	always #50 fclk = ~fclk;

	// every video word in arrival order
	always @(negedge fclk)
	begin
		if (!reset && pix_strobe)
		begin
			pix_hist.push_back(pix_word);
			nwords = nwords + 1;
		end
	end

	always @(posedge fclk)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout: the run did not finish within %0d clock cycles", limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// model and checks
	////////////////////////////////////////////////////////////

	// byte address is {page, 14-bit window offset}
	function automatic int byte_index(input zaddr_t a);
		return int'({model_map[a[15:14]], a[13:0]});
	endfunction

	function automatic word_t model_word(input page_t pg, input int ofs);
		int w;
		w = int'(pg) * (1 << `WIN_OFS_W) + ofs;
		return {model_mem[2 * w + 1], model_mem[2 * w]};
	endfunction

	task automatic check_value(input string name, input word_t exp, input word_t act);
		assert (act === exp)
		else
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_enable(input string name, input logic en, input logic want);
		assert (en === want)
		else
		begin
			if (want)
				$display("%s: nothing was driven onto the data bus during the read", name);
			else
				$display("%s: an unmatched port drove the data bus", name);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////////////////////////

	task automatic mem_write(input zaddr_t a, input byte_t d);
		@(negedge fclk);
		z_a    = a;
		z_din  = d;
		mreq_n = 1'b0;
		wr_n   = 1'b0;
		@(negedge fclk);
		while (!wait_n)
			@(negedge fclk);
		mreq_n = 1'b1;
		wr_n   = 1'b1;
		model_mem[byte_index(a)] = d;
	endtask

	task automatic mem_read(input zaddr_t a, output byte_t d, output logic en);
		@(negedge fclk);
		z_a    = a;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		@(negedge fclk);
		while (!wait_n)
			@(negedge fclk);
		d      = z_dout;
		en     = z_dout_en;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
	endtask

	task automatic io_write(input zaddr_t a, input byte_t d);
		@(negedge fclk);
		z_a    = a;
		z_din  = d;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		@(negedge fclk);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		if (a[7:0] == `PORT_PAGE_LO)
			model_map[a[15:14]] = d[`PAGE_W-1:0];
		if (a[7:0] == `PORT_SCR_LO)
			model_scr = d[3];
	endtask

	task automatic io_read(input zaddr_t a, output byte_t d, output logic en);
		@(negedge fclk);
		z_a    = a;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		@(negedge fclk);
		d      = z_dout;
		en     = z_dout_en;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// video and test sequencing
	////////////////////////////////////////////////////////////

	// burst number since reset gives the line
	task automatic check_burst(input string name, input int base);
		int    line;
		page_t pg;
		wait (nwords >= base + `FETCH_WORDS);
		line = (base / `FETCH_WORDS) % `LINES_PER_FRAME;
		pg   = model_scr ? page_t'(`SCR1_PAGE) : page_t'(`SCR0_PAGE);
		for (int i = 0; i < `FETCH_WORDS; i++)
			check_value($sformatf("%s word %0d", name, i),
				model_word(pg, line * `FETCH_WORDS + i), pix_hist[base + i]);
	endtask

	// known data in every screen word both screens can show
	task automatic fill_screens();
		page_t prev;
		prev = model_map[3];
		for (int s = 0; s < 2; s++)
		begin
			io_write(16'hC0F7, s ? byte_t'(`SCR1_PAGE) : byte_t'(`SCR0_PAGE));
			for (int i = 0; i < 2 * `FETCH_WORDS * `LINES_PER_FRAME; i++)
				mem_write(16'hC000 + zaddr_t'(i), byte_t'($urandom));
		end
		io_write(16'hC0F7, byte_t'(prev));
	endtask

	task automatic run_entry(input string name, input vec_t v);
		byte_t rd;
		logic  en;
		int    base;
		case (v.kind)
			K_IOW:
				io_write(v.addr, v.data);
			K_IOR:
			begin
				io_read(v.addr, rd, en);
				check_enable(name, en, 1'b1);
				check_value(name, word_t'(v.exp), word_t'(rd));
			end
			K_IONA:
			begin
				io_read(v.addr, rd, en);
				check_enable(name, en, 1'b0);
			end
			K_MW:
				mem_write(v.addr, v.data);
			K_MR:
			begin
				mem_read(v.addr, rd, en);
				check_enable(name, en, 1'b1);
				check_value(name, word_t'(v.exp), word_t'(rd));
			end
			K_VID:
			begin
				io_write(v.addr, v.data);
				// a burst in flight may still carry the old screen
				repeat (`LINE_CYCLES) @(negedge fclk);
				@(posedge fclk);
				wait (nwords % `FETCH_WORDS == 0);
				base = nwords;
				check_burst(name, base);
			end
			K_CONT:
			begin
				// video still owns the grant once its first word is back
				@(posedge fclk);
				wait (nwords % `FETCH_WORDS == 1);
				base = nwords - 1;
				mem_write(v.addr, v.data);
				// the read goes into the following burst
				wait (nwords >= base + `FETCH_WORDS + 1);
				mem_read(v.addr, rd, en);
				check_enable(name, en, 1'b1);
				check_value(name, word_t'(v.exp), word_t'(rd));
				check_burst(name, base);
				check_burst(name, base + `FETCH_WORDS);
			end
			default:
			begin
				$display("%s: unknown table entry kind", name);
				errors++;
			end
		endcase
	endtask

	task automatic run_test(input int idx);
		int err_before;
		err_before = errors;
		run_entry(names[idx], vecs[idx]);
		if (errors == err_before)
		begin
			n_pass++;
			$display("test %s: pass", names[idx]);
		end
		else
		begin
			n_fail++;
			$display("test %s: fail", names[idx]);
		end
	endtask

	function automatic void add_entry(input string name, input kind_t kind, input zaddr_t addr,
			input byte_t data, input byte_t exp);
		vec_t v;
		v.kind = kind;
		v.addr = addr;
		v.data = data;
		v.exp  = exp;
		names.push_back(name);
		vecs.push_back(v);
	endfunction

	function automatic void build_table();
		add_entry("page_rst_w0",    K_IOR,  16'h00F7, 8'h00, 8'h00);
		add_entry("page_rst_w1",    K_IOR,  16'h40F7, 8'h00, 8'h01);
		add_entry("page_rst_w2",    K_IOR,  16'h80F7, 8'h00, 8'h02);
		add_entry("page_rst_w3",    K_IOR,  16'hC0F7, 8'h00, 8'h03);
		add_entry("page_set_w2",    K_IOW,  16'h80F7, 8'h06, 8'h00);
		add_entry("page_rd_w2",     K_IOR,  16'h80F7, 8'h00, 8'h06);
		add_entry("no_port",        K_IONA, 16'h00FE, 8'h00, 8'h00);
		add_entry("wr_even",        K_MW,   16'h4100, 8'hA5, 8'h00);
		add_entry("wr_odd",         K_MW,   16'h4101, 8'h3C, 8'h00);
		add_entry("rd_even",        K_MR,   16'h4100, 8'h00, 8'hA5);
		add_entry("rd_odd",         K_MR,   16'h4101, 8'h00, 8'h3C);
		add_entry("odd_again",      K_MW,   16'h4101, 8'h77, 8'h00);
		add_entry("even_kept",      K_MR,   16'h4100, 8'h00, 8'hA5);
		add_entry("odd_new",        K_MR,   16'h4101, 8'h00, 8'h77);
		// window 1 shares page 6 with window 2 and then goes back
		add_entry("pre_alias",      K_MW,   16'h4222, 8'h11, 8'h00);
		add_entry("map_w1_p6",      K_IOW,  16'h40F7, 8'h06, 8'h00);
		add_entry("alias_wr",       K_MW,   16'h4222, 8'h5A, 8'h00);
		add_entry("alias_rd",       K_MR,   16'h8222, 8'h00, 8'h5A);
		add_entry("remap_w1",       K_IOW,  16'h40F7, 8'h01, 8'h00);
		add_entry("remap_rd",       K_MR,   16'h4222, 8'h00, 8'h11);
		add_entry("alias_kept",     K_MR,   16'h8222, 8'h00, 8'h5A);
		add_entry("vid_scr0",       K_VID,  16'h00FD, 8'h00, 8'h00);
		add_entry("vid_scr1",       K_VID,  16'h00FD, 8'h08, 8'h00);
		add_entry("page_after_scr", K_IOR,  16'hC0F7, 8'h00, 8'h03);
		add_entry("vid_scr1_next",  K_VID,  16'h00FD, 8'h08, 8'h00);
		add_entry("cont_w0",        K_CONT, 16'h0010, 8'hC3, 8'hC3);
		add_entry("cont_w3",        K_CONT, 16'hC031, 8'h96, 8'h96);
		add_entry("cont_w1",        K_CONT, 16'h7FFF, 8'hE1, 8'hE1);
		add_entry("vid_scr0_back",  K_VID,  16'h00FD, 8'h00, 8'h00);
		add_entry("rd_after_cont",  K_MR,   16'h0010, 8'h00, 8'hC3);
	endfunction

	initial
	begin
		fclk   = 1'b0;
		reset  = 1'b1;
		z_a    = '0;
		z_din  = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		nwords = 0;
		cycles = 0;
		errors = 0;
		n_pass = 0;
		n_fail = 0;
		filled = 1'b0;
		seed   = $urandom(32'h86c0);
		for (int i = 0; i < `NUM_WIN; i++)
			model_map[i] = page_t'(i);
		model_scr = 1'b0;
		build_table();
		limit = names.size() * 4 * `LINE_CYCLES;

		repeat (3) @(negedge fclk);
		reset = 1'b0;

		for (int i = 0; i < names.size(); i++)
		begin
			// screen pages get known data before the first video test
			if (!filled && (vecs[i].kind == K_VID || vecs[i].kind == K_CONT))
			begin
				fill_screens();
				filled = 1'b1;
			end
			run_test(i);
		end

		$display("tests %0d, passed %0d, failed %0d, check errors %0d",
			names.size(), n_pass, n_fail, errors);
		if (errors == 0 && n_fail == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+design
design/zx_pkg.sv
design/port_regs.sv
design/cpu_mem.sv
design/dram_arbiter.sv
design/dram_ctrl.sv
design/video_fetch.sv
design/zx_core.sv
sim/tb_zx_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_zx_core -o tb_zx_core

./obj_dir/tb_zx_core | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
